// File: Bender.yml
package:
  name: cpu4

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpu_pkg.sv
      - verilog/cpu_alu.sv
      - verilog/cpu_regs.sv
      - verilog/cpu_microcode.sv
      - verilog/cpu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/cpu_checker.sv
      - test/bench.sv

// File: tb.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_regs.sv
verilog/cpu_microcode.sv
verilog/cpu.sv
test/cpu_checker.sv
test/bench.sv

// File: test/bench.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module bench;
  import cpu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 4;
  localparam int HOLD_CYCLES = 20;
  localparam int NUM_TESTS = 5;
  localparam int PROG_WORDS = 282;  // All five programs together
  localparam int WATCHDOG_CYCLES =
    PROG_WORDS * 5 + NUM_TESTS * (RESET_CYCLES + 2) + HOLD_CYCLES + 200;

  logic    clk;
  logic    reset_n;
  pc_t     rom_addr;
  instr_t  rom_data;
  addr_t   memory_addr;
  logic    memory_write_en;
  nibble_t memory_write_data;
  nibble_t memory_read_data;
  logic    halt;

  instr_t  rom [0:(1 << `CPU_PC_WIDTH) - 1];
  nibble_t ram [0:`CPU_RAM_DEPTH - 1];
  nibble_t exp_ram [0:`CPU_RAM_DEPTH - 1];

  // Reference register state
  nibble_t m_a;
  nibble_t m_b;
  addr_t   m_x;
  addr_t   m_y;
  logic    m_c;
  logic    m_z;
  logic    m_d;

  int   prog_pc;
  int   prog_len;
  int   errors;
  int   checks;

  cpu u_dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .rom_addr          (rom_addr),
    .rom_data          (rom_data),
    .memory_addr       (memory_addr),
    .memory_write_en   (memory_write_en),
    .memory_write_data (memory_write_data),
    .memory_read_data  (memory_read_data),
    .halt              (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Registered ROM and RAM models
  always @(posedge clk) begin
    rom_data <= rom[rom_addr];
    if (memory_write_en === 1'b1) begin
      ram[memory_addr] <= memory_write_data;
    end else begin
      memory_read_data <= ram[memory_addr];
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic put(input instr_t word);
    rom[prog_pc] = word;
    prog_pc++;
    prog_len++;
  endtask

  task automatic op_ldx(input logic [7:0] v);
    put({4'h4, v});
    m_x = {4'h0, v};
  endtask

  task automatic op_ldy(input logic [7:0] v);
    put({4'h5, v});
    m_y = {4'h0, v};
  endtask

  // Skipped instructions leave the model alone
  task automatic op_ldr(input logic [1:0] dst, input nibble_t v, input bit live);
    put({4'h6, 2'b00, dst, v});
    if (live) begin
      case (dst)
        2'd0: m_a = v;
        2'd1: m_b = v;
        2'd2: exp_ram[m_x] = v;
        default: exp_ram[m_y] = v;
      endcase
    end
  endtask

  task automatic op_jump(input logic [3:0] cond, input int target);
    put({cond, target[7:0]});  // Page offset only
  endtask

  function automatic nibble_t operand(input logic [1:0] sel);
    case (sel)
      2'd0: return m_a;
      2'd1: return m_b;
      2'd2: return exp_ram[m_x];
      default: return exp_ram[m_y];
    endcase
  endfunction

  task automatic op_alu(input logic [2:0] op, input logic [1:0] q);
    int      s;
    nibble_t r_v;
    nibble_t q_v;
    nibble_t res;
    r_v = exp_ram[m_x];
    q_v = operand(q);
    put({4'h7, 1'b0, op, 2'd2, q});
    case (op)
      3'd0: begin
        s = r_v + q_v;
        if (m_d && s > 9) begin
          s = s + 6;
          m_c = 1'b1;
        end else begin
          m_c = (s > 15);
        end
      end
      3'd1: begin
        m_c = (r_v < q_v);  // Borrow
        s = r_v - q_v;
        if (m_d && m_c) s = s - 6;
      end
      3'd2: s = r_v & q_v;
      3'd3: s = r_v | q_v;
      default: s = r_v ^ q_v;
    endcase
    res = s[3:0];
    m_z = (res == 4'h0);
    exp_ram[m_x] = res;
  endtask

  task automatic op_decimal(input bit on);
    put({4'h9, 7'd0, on});
    m_d = on;
  endtask

  // One ALU case with its carry and zero markers in 16 words
  task automatic alu_case(input int idx, input logic [2:0] op, input nibble_t rv,
                          input logic [1:0] qsel, input nibble_t qv);
    op_ldx(8'h10 + idx);
    op_ldr(2'd2, rv, 1'b1);
    op_ldy(8'h40 + idx);
    op_ldr(2'd3, qv, 1'b1);
    op_ldr(2'd0, qv, 1'b1);
    op_ldr(2'd1, ~qv, 1'b1);
    op_alu(op, qsel);
    op_ldy(8'h80 + idx);
    op_jump(4'h2, prog_pc + 2);
    op_ldr(2'd3, 4'hC, m_c);
    op_jump(4'h1, prog_pc + 2);
    op_ldr(2'd3, 4'h5, !m_c);
    op_ldy(8'hA0 + idx);
    op_jump(4'h3, prog_pc + 2);
    op_jump(4'h0, prog_pc + 2);
    op_ldr(2'd3, 4'hA, m_z);
  endtask

  task automatic start_program();
    @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    for (int i = 0; i < (1 << `CPU_PC_WIDTH); i++) rom[i] = 12'hE00;
    for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
      ram[i] = 4'h0;
      exp_ram[i] = 4'h0;
    end
    prog_pc = `CPU_RESET_PC;
    prog_len = 0;
    m_a = 4'h0;
    m_b = 4'h0;
    m_x = '0;
    m_y = '0;
    m_c = 1'b0;
    m_z = 1'b0;
    m_d = 1'b0;
  endtask

  task automatic run_program();
    int limit;
    limit = prog_len * 5 + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b0;
    @(negedge clk);
    check_value("rom_addr", rom_addr, `CPU_RESET_PC);
    check_value("memory_write_en", memory_write_en, 1'b0);
    check_value("halt", halt, 1'b0);
    for (int n = 0; n < limit && halt !== 1'b1; n++) @(negedge clk);
    if (halt !== 1'b1) begin
      errors++;
      $display("Program did not reach HALT within %0d cycles", limit);
    end
  endtask

  task automatic compare_ram();
    for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
      check_value($sformatf("ram[%03h]", i), ram[i], exp_ram[i]);
    end
  endtask

  task automatic test_loads();
    start_program();
    op_ldx(8'h3A);
    op_ldr(2'd2, $urandom_range(0, 15), 1'b1);
    op_ldy(8'hC5);
    op_ldr(2'd3, $urandom_range(0, 15), 1'b1);
    put(12'h800);
    m_x = m_x + 1;
    op_ldr(2'd2, $urandom_range(0, 15), 1'b1);
    put(12'h800);
    m_x = m_x + 1;
    op_ldr(2'd2, $urandom_range(0, 15), 1'b1);
    put(12'hE00);
    run_program();
    compare_ram();
  endtask

  task automatic test_alu_flags();
    logic [2:0] op;
    start_program();
    for (int i = 0; i < 8; i++) begin
      op = (i < 5) ? i[2:0] : 3'($urandom_range(0, 4));  // Each op at least once
      alu_case(i, op, $urandom_range(0, 15), $urandom_range(0, 3), $urandom_range(0, 15));
    end
    put(12'hE00);
    run_program();
    compare_ram();
  endtask

  task automatic test_decimal();
    nibble_t    rv [4];
    nibble_t    qv [4];
    logic [1:0] qs [4];
    start_program();
    for (int i = 0; i < 4; i++) begin
      rv[i] = $urandom_range(0, 9);
      qv[i] = $urandom_range(0, 9);
      qs[i] = $urandom_range(0, 2);
      if (qs[i] == 2'd1) begin
        qs[i] = 2'd3;  // B holds the complement, not a digit
      end
    end
    op_decimal(1'b1);
    for (int i = 0; i < 4; i++) alu_case(i, i[0], rv[i], qs[i], qv[i]);
    op_decimal(1'b0);
    for (int i = 0; i < 4; i++) alu_case(i + 4, i[0], rv[i], qs[i], qv[i]);
    put(12'hE00);
    run_program();
    compare_ram();
  endtask

  task automatic test_jump_skip();
    start_program();
    op_ldx(8'h60);
    op_jump(4'h0, prog_pc + 4);
    op_ldr(2'd2, 4'h7, 1'b0);
    put(12'h800);  // Skipped INC X
    op_ldr(2'd2, 4'h9, 1'b0);
    op_ldy(8'h70);
    op_ldr(2'd3, 4'h2, 1'b1);
    put(12'hE00);
    run_program();
    compare_ram();
  endtask

  task automatic test_halt_hold();
    int halt_pc;
    start_program();
    op_ldx(8'h05);
    op_ldr(2'd2, 4'h3, 1'b1);
    halt_pc = prog_pc;
    put(12'hE00);
    op_ldr(2'd2, 4'hF, 1'b0);
    put(12'hE00);
    run_program();
    check_value("rom_addr", rom_addr, halt_pc);
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value("halt", halt, 1'b1);
      check_value("rom_addr", rom_addr, halt_pc);
      check_value("memory_write_en", memory_write_en, 1'b0);
    end
    compare_ram();
  endtask

  initial begin
    int asserts;
    reset_n = 1'b1;
    rom_data = '0;
    memory_read_data = '0;
    errors = 0;
    checks = 0;
    void'($urandom(92539));
    test_loads();
    test_alu_flags();
    test_decimal();
    test_jump_skip();
    test_halt_hold();
    asserts = u_dut.u_checker.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, asserts);
    if (errors == 0 && asserts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/cpu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_checker (
  input logic         clk,
  input logic         reset_n,
  input cpu_pkg::pc_t rom_addr,
  input logic         memory_write_en,
  input logic         halt
);
  import cpu_pkg::*;

  int fail_count = 0;  // Read by the testbench

  a_no_write_in_reset: assert property (@(posedge clk) reset_n |-> !memory_write_en)
    else begin
      fail_count++;
      $error("memory_write_en high during reset");
    end

  a_halted_quiet: assert property (@(posedge clk) disable iff (reset_n)
    halt |=> $stable(rom_addr) && !memory_write_en)
    else begin
      fail_count++;
      $error("rom_addr moved or a write happened while halted");
    end

  // Only reset leaves HALTED
  a_halt_sticky: assert property (@(posedge clk) disable iff (reset_n) halt |=> halt)
    else begin
      fail_count++;
      $error("halt dropped without reset");
    end

endmodule

bind cpu cpu_checker u_checker (
  .clk             (clk),
  .reset_n         (reset_n),
  .rom_addr        (rom_addr),
  .memory_write_en (memory_write_en),
  .halt            (halt)
);

`default_nettype wire

// File: verilog/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu (
  input  logic             clk,
  input  logic             reset_n,
  output cpu_pkg::pc_t     rom_addr,
  input  cpu_pkg::instr_t  rom_data,
  output cpu_pkg::addr_t   memory_addr,
  output logic             memory_write_en,
  output cpu_pkg::nibble_t memory_write_data,
  input  cpu_pkg::nibble_t memory_read_data,
  output logic             halt
);
  import cpu_pkg::*;

  reg_ctrl_t  ctrl;
  reg_state_t state;
  alu_op_e    alu_op;
  nibble_t    alu_r;
  nibble_t    alu_q;
  nibble_t    alu_result;
  logic       alu_carry;
  logic       alu_zero;

  cpu_microcode microcode (
    .clk               (clk),
    .reset_n           (reset_n),
    .rom_addr          (rom_addr),
    .rom_data          (rom_data),
    .memory_addr       (memory_addr),
    .memory_write_en   (memory_write_en),
    .memory_write_data (memory_write_data),
    .memory_read_data  (memory_read_data),
    .state             (state),
    .alu_result        (alu_result),
    .alu_carry         (alu_carry),
    .alu_zero          (alu_zero),
    .alu_op            (alu_op),
    .alu_r             (alu_r),
    .alu_q             (alu_q),
    .ctrl              (ctrl),
    .halt              (halt)
  );

  // ROM output holds the instruction until the PC moves
  cpu_regs regs (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl),
    .imm     (rom_data[3:0]),
    .state   (state)
  );

  cpu_alu alu (
    .op        (alu_op),
    .r_val     (alu_r),
    .q_val     (alu_q),
    .flags     (state.flags),
    .result    (alu_result),
    .carry_out (alu_carry),
    .zero_out  (alu_zero)
  );

endmodule

`default_nettype wire

// File: verilog/cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::nibble_t r_val,
  input  cpu_pkg::nibble_t q_val,
  input  cpu_pkg::flags_t  flags,
  output cpu_pkg::nibble_t result,
  output logic             carry_out,
  output logic             zero_out
);
  import cpu_pkg::*;

  logic [4:0] sum;   // Extra bit for carry
  logic [4:0] diff;  // Extra bit for borrow

  always_comb begin
    sum = {1'b0, r_val} + {1'b0, q_val};
    diff = {1'b0, r_val} - {1'b0, q_val};
    result = r_val;
    carry_out = flags.carry;

    case (op)
      ALU_ADD: begin
        if (flags.decimal && sum > 5'd9) begin
          // BCD correction, digit wraps past 9
          sum = sum + 5'd6;
          carry_out = 1'b1;
        end else begin
          carry_out = sum[4];
        end
        result = sum[3:0];
      end
      ALU_SUB: begin
        carry_out = diff[4];
        if (flags.decimal && diff[4]) begin
          diff = diff - 5'd6;
        end
        result = diff[3:0];
      end
      ALU_AND: begin
        result = r_val & q_val;
      end
      ALU_OR: begin
        result = r_val | q_val;
      end
      ALU_XOR: begin
        result = r_val ^ q_val;
      end
      default: begin
        result = r_val;  // Unused op codes pass r
      end
    endcase

    zero_out = (result == '0);
  end

endmodule

`default_nettype wire

// File: verilog/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Core widths
`define CPU_PC_WIDTH    13
`define CPU_ADDR_WIDTH  12
`define CPU_DATA_WIDTH  4
`define CPU_INSTR_WIDTH 12

// Program memory
`define CPU_RESET_PC    13'h100

// Data RAM, 4096 nibbles
`define CPU_RAM_DEPTH   4096

`endif

// File: verilog/cpu_microcode.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_microcode (
  input  logic                clk,
  input  logic                reset_n,
  output cpu_pkg::pc_t        rom_addr,
  input  cpu_pkg::instr_t     rom_data,
  output cpu_pkg::addr_t      memory_addr,
  output logic                memory_write_en,
  output cpu_pkg::nibble_t    memory_write_data,
  input  cpu_pkg::nibble_t    memory_read_data,
  input  cpu_pkg::reg_state_t state,
  input  cpu_pkg::nibble_t    alu_result,
  input  logic                alu_carry,
  input  logic                alu_zero,
  output cpu_pkg::alu_op_e    alu_op,
  output cpu_pkg::nibble_t    alu_r,
  output cpu_pkg::nibble_t    alu_q,
  output cpu_pkg::reg_ctrl_t  ctrl,
  output logic                halt
);
  import cpu_pkg::*;

  localparam logic [3:0] OP_JP   = 4'h0;
  localparam logic [3:0] OP_JC   = 4'h1;
  localparam logic [3:0] OP_JNC  = 4'h2;
  localparam logic [3:0] OP_JZ   = 4'h3;
  localparam logic [3:0] OP_LDX  = 4'h4;
  localparam logic [3:0] OP_LDY  = 4'h5;
  localparam logic [3:0] OP_LDR  = 4'h6;
  localparam logic [3:0] OP_ALU  = 4'h7;
  localparam logic [3:0] OP_INCX = 4'h8;
  localparam logic [3:0] OP_DEC  = 4'h9;
  localparam logic [3:0] OP_HALT = 4'hE;

  localparam reg_sel_t SEL_A = 2'd0;
  localparam reg_sel_t SEL_B = 2'd1;

  seq_state_e seq_q;
  instr_t     instr_q;
  nibble_t    opnd_r_q;
  nibble_t    opnd_q_q;
  logic       second_q;  // Next read fills the q operand

  logic [3:0] dec_opcode;
  reg_sel_t   dec_r;
  reg_sel_t   dec_q;
  logic       dec_r_mem;
  logic       dec_q_mem;

  logic [3:0] opcode;
  reg_sel_t   r_sel;
  reg_sel_t   q_sel;
  reg_sel_t   dst_sel;
  logic       jump_taken;
  nibble_t    wdata;

  function automatic addr_t sel_addr(reg_sel_t sel, reg_state_t regs);
    return sel[0] ? regs.y : regs.x;
  endfunction

  function automatic nibble_t operand_value(reg_sel_t sel, reg_state_t regs, nibble_t mem_val);
    case (sel)
      SEL_A: return regs.a;
      SEL_B: return regs.b;
      default: return mem_val;
    endcase
  endfunction

  // Decode straight from the ROM output
  assign dec_opcode = rom_data[11:8];
  assign dec_r = rom_data[3:2];
  assign dec_q = rom_data[1:0];
  assign dec_r_mem = (dec_opcode == OP_ALU) && dec_r[1];
  assign dec_q_mem = (dec_opcode == OP_ALU) && dec_q[1];

  assign opcode = instr_q[11:8];
  assign r_sel = instr_q[3:2];
  assign q_sel = instr_q[1:0];
  assign dst_sel = (opcode == OP_ALU) ? r_sel : instr_q[5:4];

  always_ff @(posedge clk) begin
    if (reset_n) begin
      seq_q <= FETCH;
      second_q <= 1'b0;
    end else begin
      case (seq_q)
        FETCH: seq_q <= DECODE;
        DECODE: begin
          second_q <= !dec_r_mem;
          if (dec_opcode == OP_HALT) begin
            seq_q <= HALTED;
          end else if (dec_r_mem || dec_q_mem) begin
            seq_q <= READ_OPERAND;
          end else begin
            seq_q <= EXECUTE;
          end
        end
        READ_OPERAND: begin
          if (!second_q && q_sel[1]) begin
            second_q <= 1'b1;  // Stay for the q operand
          end else begin
            seq_q <= EXECUTE;
          end
        end
        EXECUTE: seq_q <= FETCH;
        HALTED: seq_q <= HALTED;
        default: seq_q <= FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (seq_q == DECODE) begin
      instr_q <= rom_data;
    end
    if (seq_q == READ_OPERAND) begin
      if (second_q) begin
        opnd_q_q <= memory_read_data;
      end else begin
        opnd_r_q <= memory_read_data;
      end
    end
  end

  assign rom_addr = state.pc;
  assign halt = (seq_q == HALTED);

  assign alu_op = alu_op_e'(instr_q[6:4]);
  assign alu_r = operand_value(r_sel, state, opnd_r_q);
  assign alu_q = operand_value(q_sel, state, opnd_q_q);

  always_comb begin
    case (opcode)
      OP_JP:   jump_taken = 1'b1;
      OP_JC:   jump_taken = state.flags.carry;
      OP_JNC:  jump_taken = !state.flags.carry;
      OP_JZ:   jump_taken = state.flags.zero;
      default: jump_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (seq_q)
      DECODE:       memory_addr = sel_addr(dec_r_mem ? dec_r : dec_q, state);
      READ_OPERAND: memory_addr = sel_addr(q_sel, state);
      default:      memory_addr = sel_addr(dst_sel, state);  // Write target
    endcase
  end

  always_comb begin
    if (opcode == OP_ALU) begin
      wdata = alu_result;
    end else if (opcode == OP_LDX || opcode == OP_LDY) begin
      wdata = instr_q[7:4];
    end else begin
      wdata = instr_q[3:0];
    end
  end

  assign memory_write_data = wdata;

  always_comb begin
    ctrl = '0;
    ctrl.wdata = wdata;
    ctrl.pc_value = {state.pc[`CPU_PC_WIDTH-1:8], instr_q[7:0]};  // Same page
    ctrl.new_flags = state.flags;
    memory_write_en = 1'b0;

    if (seq_q == EXECUTE) begin
      ctrl.pc_load = jump_taken;
      ctrl.pc_inc = !jump_taken;
      case (opcode)
        OP_LDX: ctrl.x_we = 1'b1;
        OP_LDY: ctrl.y_we = 1'b1;
        OP_INCX: begin
          ctrl.x_we = 1'b1;
          ctrl.x_src_inc = 1'b1;
        end
        OP_DEC: begin
          ctrl.flags_we = 1'b1;
          ctrl.new_flags.decimal = instr_q[0];
        end
        OP_LDR, OP_ALU: begin
          if (opcode == OP_ALU) begin
            ctrl.flags_we = 1'b1;
            ctrl.new_flags.carry = alu_carry;
            ctrl.new_flags.zero = alu_zero;
          end
          case (dst_sel)
            SEL_A:   ctrl.a_we = 1'b1;
            SEL_B:   ctrl.b_we = 1'b1;
            default: memory_write_en = 1'b1;  // MX or MY
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_PC_WIDTH-1:0]    pc_t;
  typedef logic [`CPU_ADDR_WIDTH-1:0]  addr_t;
  typedef logic [`CPU_DATA_WIDTH-1:0]  nibble_t;
  typedef logic [`CPU_INSTR_WIDTH-1:0] instr_t;

  // 0 A, 1 B, 2 MX, 3 MY
  typedef logic [1:0] reg_sel_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic decimal;
  } flags_t;

  typedef struct packed {
    pc_t     pc;
    nibble_t a;
    nibble_t b;
    addr_t   x;
    addr_t   y;
    flags_t  flags;
  } reg_state_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  typedef struct packed {
    logic    a_we;
    logic    b_we;
    logic    x_we;
    logic    y_we;
    logic    flags_we;
    logic    x_src_inc;  // X from increment, else immediate
    logic    pc_inc;
    logic    pc_load;
    pc_t     pc_value;
    nibble_t wdata;
    flags_t  new_flags;
  } reg_ctrl_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    READ_OPERAND,
    EXECUTE,
    HALTED
  } seq_state_e;

endpackage

`default_nettype wire

// File: verilog/cpu_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_regs (
  input  logic                clk,
  input  logic                reset_n,
  input  cpu_pkg::reg_ctrl_t  ctrl,
  input  cpu_pkg::nibble_t    imm,
  output cpu_pkg::reg_state_t state
);
  import cpu_pkg::*;

  pc_t     pc;
  nibble_t a;
  nibble_t b;
  addr_t   x;
  addr_t   y;
  flags_t  flags;

  // Low byte of an X or Y load, high nibble arrives in wdata
  addr_t   xy_imm;

  assign xy_imm = {4'h0, ctrl.wdata, imm};

  always_ff @(posedge clk) begin
    if (reset_n) begin
      pc <= `CPU_RESET_PC;
      flags <= '0;
    end else begin
      if (ctrl.pc_load) begin
        pc <= ctrl.pc_value;
      end else if (ctrl.pc_inc) begin
        pc <= pc + 1'b1;
      end

      if (ctrl.flags_we) begin
        flags <= ctrl.new_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.a_we) begin
      a <= ctrl.wdata;
    end
    if (ctrl.b_we) begin
      b <= ctrl.wdata;
    end

    if (ctrl.x_we) begin
      if (ctrl.x_src_inc) begin
        x <= x + 1'b1;  // Wraps at 12 bits
      end else begin
        x <= xy_imm;
      end
    end

    if (ctrl.y_we) begin
      y <= xy_imm;
    end
  end

  assign state = '{
    pc:    pc,
    a:     a,
    b:     b,
    x:     x,
    y:     y,
    flags: flags
  };

endmodule

`default_nettype wire
